//--- rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int result_width = 64;
    localparam int offset_width = 3; // byte offset within a doubleword

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } ls_op_e;

    // access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } ls_size_e;

    typedef struct packed {
        ls_op_e                  op;
        ls_size_e                size;
        logic                    is_unsigned; // zero-extend loads when set
        logic [result_width-1:0] address;
        logic [result_width-1:0] data;        // store data, unused for loads
    } ls_req_t;

endpackage

`default_nettype wire

//--- rtl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    localparam int mem_depth = 256;  // doublewords
    localparam int mem_latency = 3;  // accept edge to done pulse
    localparam int mem_index_width = $clog2(mem_depth);
    localparam int mem_latency_width = $clog2(mem_latency + 1);

    localparam int bus_data_width = lsu_pkg::result_width;
    localparam int byte_lanes = bus_data_width / 8;
    localparam int bus_addr_width = lsu_pkg::result_width - lsu_pkg::offset_width;

    typedef logic [bus_addr_width-1:0] bus_addr_t; // doubleword index
    typedef logic [mem_latency_width-1:0] lat_cnt_t;

    typedef struct packed {
        bus_addr_t                 address;
        logic [bus_data_width-1:0] data; // already shifted into its byte lanes
        logic [byte_lanes-1:0]     mask; // one bit per byte lane
    } bus_write_t;

endpackage

`default_nettype wire

//--- rtl/mem.sv
`timescale 1ns/1ps
`default_nettype none

module mem (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire lsu_pkg::ls_req_t  ls_req,

    output logic                   read_valid,
    input  wire                    read_ready,
    output mem_bus_pkg::bus_addr_t read_address,
    input  wire                    read_done,

    output logic                   write_valid,
    input  wire                    write_ready,
    output mem_bus_pkg::bus_write_t write_req,
    input  wire                    write_done,

    output logic                   ls_done
);

    logic is_load;
    logic is_store;
    logic read_fire;
    logic write_fire;
    logic read_outstanding;
    logic write_outstanding;

    logic [lsu_pkg::offset_width-1:0] byte_offset;
    logic [mem_bus_pkg::byte_lanes-1:0] size_mask;
    logic [mem_bus_pkg::byte_lanes-1:0] lane_mask;
    logic [mem_bus_pkg::bus_data_width-1:0] lane_data;
    mem_bus_pkg::bus_addr_t dword_address;

    assign is_load  = ls_req.op == lsu_pkg::op_load;
    assign is_store = ls_req.op == lsu_pkg::op_store;

    assign read_fire  = read_valid & read_ready;
    assign write_fire = write_valid & write_ready;

    // one flag per channel, set on transfer and cleared by its done pulse
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_outstanding <= 1'b0;
        end else if (read_fire) begin
            read_outstanding <= 1'b1;
        end else if (read_done) begin
            read_outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_outstanding <= 1'b0;
        end else if (write_fire) begin
            write_outstanding <= 1'b1;
        end else if (write_done) begin
            write_outstanding <= 1'b0;
        end
    end

    assign byte_offset = ls_req.address[lsu_pkg::offset_width-1:0];
    assign dword_address = ls_req.address[lsu_pkg::result_width-1:lsu_pkg::offset_width];

    always_comb begin
        case (ls_req.size)
            lsu_pkg::size_byte: size_mask = 8'h01;
            lsu_pkg::size_half: size_mask = 8'h03;
            lsu_pkg::size_word: size_mask = 8'h0f;
            default:            size_mask = 8'hff;
        endcase
    end

    assign lane_mask = size_mask << byte_offset;
    assign lane_data = ls_req.data << {byte_offset, 3'b000}; // offset in bits

    always_comb begin
        read_valid   = 1'b0;
        read_address = '0;
        write_valid  = 1'b0;
        write_req    = '0;

        if (is_load && !read_outstanding) begin
            read_valid   = 1'b1;
            read_address = dword_address;
        end
        if (is_store && !write_outstanding) begin
            write_valid       = 1'b1;
            write_req.address = dword_address;
            write_req.data    = lane_data;
            write_req.mask    = lane_mask;
        end
    end

    // a done pulse only counts for the channel that has an access in flight
    assign ls_done = (read_done & read_outstanding) | (write_done & write_outstanding);

endmodule

`default_nettype wire

//--- rtl/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire                               clock,
    input  wire                               rst_n,
    input  wire lsu_pkg::ls_req_t             ls_req,
    input  wire                               read_fire,
    input  wire                               read_done,
    input  wire [lsu_pkg::result_width-1:0]   read_data,
    output logic [lsu_pkg::result_width-1:0]  ls_result
);

    logic [lsu_pkg::offset_width-1:0] offset_q;
    lsu_pkg::ls_size_e                size_q;
    logic                             unsigned_q;

    logic [lsu_pkg::result_width-1:0] shifted;
    logic [lsu_pkg::result_width-1:0] extended;
    logic                             sign_en;

    // the request may change once done has pulsed, so keep what the alignment needs
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            offset_q   <= '0;
            size_q     <= lsu_pkg::size_byte;
            unsigned_q <= 1'b0;
        end else if (read_fire) begin
            offset_q   <= ls_req.address[lsu_pkg::offset_width-1:0];
            size_q     <= ls_req.size;
            unsigned_q <= ls_req.is_unsigned;
        end
    end

    assign shifted = read_data >> {offset_q, 3'b000};
    assign sign_en = ~unsigned_q;

    always_comb begin
        case (size_q)
            lsu_pkg::size_byte: begin
                extended = {{56{sign_en & shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::size_half: begin
                extended = {{48{sign_en & shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::size_word: begin
                extended = {{32{sign_en & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                extended = shifted;
            end
        endcase
    end

    assign ls_result = read_done ? extended : '0;

endmodule

`default_nettype wire

//--- rtl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  wire                                     clock,
    input  wire                                     rst_n,

    input  wire                                     read_valid,
    output logic                                    read_ready,
    input  wire mem_bus_pkg::bus_addr_t             read_address,
    output logic                                    read_done,
    output logic [mem_bus_pkg::bus_data_width-1:0]  read_data,

    input  wire                                     write_valid,
    output logic                                    write_ready,
    input  wire mem_bus_pkg::bus_write_t            write_req,
    output logic                                    write_done
);

    logic [mem_bus_pkg::bus_data_width-1:0] ram [mem_bus_pkg::mem_depth];

    mem_bus_pkg::lat_cnt_t lat_cnt;
    logic                  read_pending; // current busy window belongs to a read
    logic                  busy;
    logic                  read_fire;
    logic                  write_fire;
    logic                  last_cycle;

    logic [mem_bus_pkg::mem_index_width-1:0] read_index;
    logic [mem_bus_pkg::mem_index_width-1:0] write_index;

    assign busy = lat_cnt != '0;
    assign last_cycle = lat_cnt == mem_bus_pkg::lat_cnt_t'(1);

    // read wins a tie
    assign read_ready  = ~busy;
    assign write_ready = ~busy & ~read_valid;

    assign read_fire  = read_valid & read_ready;
    assign write_fire = write_valid & write_ready;

    assign read_index  = read_address[mem_bus_pkg::mem_index_width-1:0];
    assign write_index = write_req.address[mem_bus_pkg::mem_index_width-1:0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt      <= '0;
            read_pending <= 1'b0;
            read_done    <= 1'b0;
            write_done   <= 1'b0;
            for (int i = 0; i < mem_bus_pkg::mem_depth; i++) begin
                ram[i] <= '0;
            end
        end else begin
            read_done  <= last_cycle & read_pending;
            write_done <= last_cycle & ~read_pending;

            if (read_fire) begin
                lat_cnt      <= mem_bus_pkg::lat_cnt_t'(mem_bus_pkg::mem_latency);
                read_pending <= 1'b1;
            end else if (write_fire) begin
                lat_cnt      <= mem_bus_pkg::lat_cnt_t'(mem_bus_pkg::mem_latency);
                read_pending <= 1'b0;
                for (int b = 0; b < mem_bus_pkg::byte_lanes; b++) begin
                    if (write_req.mask[b]) begin
                        ram[write_index][b*8 +: 8] <= write_req.data[b*8 +: 8];
                    end
                end
            end else if (busy) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // sampled at accept and held through the done pulse
    always_ff @(posedge clock) begin
        if (read_fire) begin
            read_data <= ram[read_index];
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                               clock,
    input  wire                               rst_n,
    input  wire lsu_pkg::ls_req_t             ls_req,
    output logic                              ls_done,
    output logic [lsu_pkg::result_width-1:0]  ls_result
);

    logic                                   read_valid;
    logic                                   read_ready;
    logic                                   read_fire;
    mem_bus_pkg::bus_addr_t                 read_address;
    logic                                   read_done;
    logic [mem_bus_pkg::bus_data_width-1:0] read_data;

    logic                                   write_valid;
    logic                                   write_ready;
    mem_bus_pkg::bus_write_t                write_req;
    logic                                   write_done;

    assign read_fire = read_valid & read_ready; // tells the aligner when to capture

    mem mem_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .ls_req       (ls_req),
        .read_valid   (read_valid),
        .read_ready   (read_ready),
        .read_address (read_address),
        .read_done    (read_done),
        .write_valid  (write_valid),
        .write_ready  (write_ready),
        .write_req    (write_req),
        .write_done   (write_done),
        .ls_done      (ls_done)
    );

    load_align load_align_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .ls_req    (ls_req),
        .read_fire (read_fire),
        .read_done (read_done),
        .read_data (read_data),
        .ls_result (ls_result)
    );

    data_ram data_ram_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_valid   (read_valid),
        .read_ready   (read_ready),
        .read_address (read_address),
        .read_done    (read_done),
        .read_data    (read_data),
        .write_valid  (write_valid),
        .write_ready  (write_ready),
        .write_req    (write_req),
        .write_done   (write_done)
    );

endmodule

`default_nettype wire

//--- testbench/lsu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
    input wire                          clock,
    input wire                          rst_n,
    input wire                          read_valid,
    input wire                          read_ready,
    input wire mem_bus_pkg::bus_addr_t  read_address,
    input wire                          read_done,
    input wire                          write_valid,
    input wire                          write_ready,
    input wire mem_bus_pkg::bus_write_t write_req,
    input wire                          write_done
);

    logic read_fire;
    logic write_fire;

    assign read_fire  = read_valid & read_ready;
    assign write_fire = write_valid & write_ready;

    read_held: assert property (@(posedge clock) disable iff (!rst_n)
        read_valid && !read_ready |=> read_valid && $stable(read_address))
        else $error("read request changed while the memory was busy");

    write_held: assert property (@(posedge clock) disable iff (!rst_n)
        write_valid && !write_ready |=> write_valid && $stable(write_req))
        else $error("write request changed while the memory was busy");

    // done is high in the cycle that starts mem_latency edges after the transfer edge
    read_done_timing: assert property (@(posedge clock) disable iff (!rst_n)
        read_done == $past(read_fire, mem_bus_pkg::mem_latency + 1))
        else $error("read_done does not follow its transfer by the fixed latency");

    write_done_timing: assert property (@(posedge clock) disable iff (!rst_n)
        write_done == $past(write_fire, mem_bus_pkg::mem_latency + 1))
        else $error("write_done does not follow its transfer by the fixed latency");

    // an access stays outstanding from its transfer edge to the end of its done cycle
    for (genvar d = 1; d <= mem_bus_pkg::mem_latency + 1; d++) begin : reissue_window
        read_no_reissue: assert property (@(posedge clock) disable iff (!rst_n)
            read_valid |-> !$past(read_fire, d))
            else $error("read_valid raised while a read is outstanding");

        write_no_reissue: assert property (@(posedge clock) disable iff (!rst_n)
            write_valid |-> !$past(write_fire, d))
            else $error("write_valid raised while a write is outstanding");
    end

endmodule

`default_nettype wire

//--- testbench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int reset_cycles = 8;
    localparam int dword_pairs = 20;
    localparam int subword_offsets = 14; // 8 byte, 4 half and 2 word positions
    localparam int random_count = 400;
    localparam int num_transactions = 2 * dword_pairs + 9 * subword_offsets + random_count;
    localparam int timeout_cycles =
        num_transactions * (mem_bus_pkg::mem_latency + 4) + reset_cycles;
    localparam int model_bytes = mem_bus_pkg::mem_depth * 8;

    typedef logic [mem_bus_pkg::mem_index_width-1:0] index_t;
    typedef logic [lsu_pkg::result_width-1:0] word_t;

    logic             clock;
    logic             rst_n;
    lsu_pkg::ls_req_t ls_req;
    logic             ls_done;
    word_t            ls_result;

    logic [7:0]  model_mem [model_bytes];
    logic [31:0] lcg_state = 32'd29022;
    int          check_count = 0;
    int          error_count = 0;
    int          transactions = 0;
    int          done_pulses = 0;
    int          cycle_count;

    lsu_top dut_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .ls_req    (ls_req),
        .ls_done   (ls_done),
        .ls_result (ls_result)
    );

    bind mem lsu_asserts lsu_asserts_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_valid   (read_valid),
        .read_ready   (read_ready),
        .read_address (read_address),
        .read_done    (read_done),
        .write_valid  (write_valid),
        .write_ready  (write_ready),
        .write_req    (write_req),
        .write_done   (write_done)
    );

    always #2 clock = ~clock;

    // a done pulse is one cycle wide, so each pulse is seen on exactly one falling edge
    always @(negedge clock) begin
        if (rst_n && ls_done) begin
            done_pulses++;
        end
    end

    function automatic logic [31:0] next_random();
        logic [15:0] upper;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        upper = lcg_state[31:16]; // low LCG bits repeat quickly
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {upper, lcg_state[31:16]};
    endfunction

    function automatic int random_index(input int range);
        return int'(next_random() % 32'(range));
    endfunction

    function automatic int size_bytes(input lsu_pkg::ls_size_e size);
        return 1 << int'(size);
    endfunction

    function automatic logic [2:0] aligned_offset(input lsu_pkg::ls_size_e size,
                                                  input logic [2:0] raw);
        return raw & ~3'(size_bytes(size) - 1);
    endfunction

    function automatic word_t make_address(input int index, input logic [2:0] offset);
        word_t address;
        address = {next_random(), next_random()}; // high bits must wrap modulo mem_depth
        address[lsu_pkg::offset_width +: mem_bus_pkg::mem_index_width] = index_t'(index);
        address[lsu_pkg::offset_width-1:0] = offset;
        return address;
    endfunction

    function automatic int byte_index(input word_t address, input int i);
        return int'((address + word_t'(i)) % word_t'(model_bytes));
    endfunction

    function automatic void model_store(input word_t address, input lsu_pkg::ls_size_e size,
                                        input word_t data);
        for (int i = 0; i < size_bytes(size); i++) begin
            model_mem[byte_index(address, i)] = data[8*i +: 8];
        end
    endfunction

    function automatic word_t model_load(input word_t address, input lsu_pkg::ls_size_e size,
                                         input logic is_unsigned);
        word_t value;
        int    nbytes;
        nbytes = size_bytes(size);
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = model_mem[byte_index(address, i)]; // little endian lanes
        end
        if (!is_unsigned && value[8*nbytes-1]) begin
            for (int b = 8 * nbytes; b < lsu_pkg::result_width; b++) begin
                value[b] = 1'b1;
            end
        end
        return value;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic drive_idle();
        @(posedge clock);
        ls_req <= '0;
    endtask

    task automatic run_access(input string name, input lsu_pkg::ls_op_e op,
                              input lsu_pkg::ls_size_e size, input logic is_unsigned,
                              input word_t address, input word_t data);
        lsu_pkg::ls_req_t req;
        int               edges;
        logic             done_seen;
        word_t            result;
        req.op = op;
        req.size = size;
        req.is_unsigned = is_unsigned;
        req.address = address;
        req.data = data;
        @(posedge clock);
        ls_req <= req;
        transactions++;
        edges = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clock);
            #1;
            edges++;
            done_seen = ls_done;
        end
        result = ls_result; // only valid while ls_done is high
        check_value({name, "_latency"}, word_t'(mem_bus_pkg::mem_latency + 1), word_t'(edges));
        if (op == lsu_pkg::op_store) begin
            model_store(address, size, data);
        end else begin
            check_value(name, model_load(address, size, is_unsigned), result);
        end
    endtask

    task automatic test_dword_roundtrip();
        word_t address;
        word_t data;
        for (int n = 0; n < dword_pairs; n++) begin
            address = make_address(random_index(mem_bus_pkg::mem_depth), 3'd0);
            data = {next_random(), next_random()};
            run_access("dword_store", lsu_pkg::op_store, lsu_pkg::size_dword, 1'b0, address, data);
            run_access("dword_load", lsu_pkg::op_load, lsu_pkg::size_dword, 1'b0, address, '0);
        end
    endtask

    task automatic test_subword_store();
        lsu_pkg::ls_size_e size;
        int                index;
        for (int s = 0; s < 3; s++) begin
            size = lsu_pkg::ls_size_e'(2'(s));
            for (int off = 0; off < 8; off += size_bytes(size)) begin
                index = random_index(mem_bus_pkg::mem_depth);
                // random background so that a stray write to any other lane shows up
                run_access("subword_fill", lsu_pkg::op_store, lsu_pkg::size_dword, 1'b0,
                           make_address(index, 3'd0), {next_random(), next_random()});
                run_access("subword_store", lsu_pkg::op_store, size, 1'b0,
                           make_address(index, 3'(off)), {next_random(), next_random()});
                run_access("subword_check", lsu_pkg::op_load, lsu_pkg::size_dword, 1'b0,
                           make_address(index, 3'd0), '0);
            end
        end
    endtask

    task automatic test_subword_load();
        lsu_pkg::ls_size_e size;
        int                index;
        word_t             data;
        word_t             address;
        for (int s = 0; s < 3; s++) begin
            size = lsu_pkg::ls_size_e'(2'(s));
            for (int off = 0; off < 8; off += size_bytes(size)) begin
                index = random_index(mem_bus_pkg::mem_depth);
                data = {next_random(), next_random()};
                address = make_address(index, 3'(off));
                // the second pass inverts the fill so every field is read with both signs
                for (int pass = 0; pass < 2; pass++) begin
                    run_access("load_fill", lsu_pkg::op_store, lsu_pkg::size_dword, 1'b0,
                               make_address(index, 3'd0), (pass == 0) ? data : ~data);
                    run_access("load_signed", lsu_pkg::op_load, size, 1'b0, address, '0);
                    run_access("load_unsigned", lsu_pkg::op_load, size, 1'b1, address, '0);
                end
            end
        end
    endtask

    task automatic test_random_mixed();
        logic [31:0]       rnd;
        lsu_pkg::ls_size_e size;
        lsu_pkg::ls_op_e   op;
        string             name;
        word_t             address;
        for (int n = 0; n < random_count; n++) begin
            rnd = next_random();
            size = lsu_pkg::ls_size_e'(rnd[1:0]);
            if (rnd[5]) begin
                op = lsu_pkg::op_load;
                name = "random_load";
            end else begin
                op = lsu_pkg::op_store;
                name = "random_store";
            end
            address = make_address(int'(rnd[11:8]), aligned_offset(size, rnd[4:2])); // 16 dwords
            if (rnd[13:12] == 2'b00) begin
                drive_idle();
            end
            run_access(name, op, size, rnd[6], address, {next_random(), next_random()});
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        ls_req = '0;
        for (int i = 0; i < model_bytes; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;

        test_dword_roundtrip();
        test_subword_store();
        test_subword_load();
        test_random_mixed();

        drive_idle();
        repeat (mem_bus_pkg::mem_latency + 2) @(posedge clock);
        check_value("done_pulses", word_t'(transactions), word_t'(done_pulses));

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/lsu_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem.sv
rtl/load_align.sv
rtl/data_ram.sv
rtl/lsu_top.sv
testbench/lsu_asserts.sv
testbench/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module lsu_tb \
    -f sources.f \
    -o lsu_sim

./obj_dir/lsu_sim 2>&1 | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
